// File: project.f
source/hps_pkg.sv
source/hps_frame.sv
source/hps_input_regs.sv
source/hps_host_query.sv
source/hps_file_loader.sv
source/hps_response_arbiter.sv
source/hps_bridge.sv
tests/hps_bridge_assertions.sv
tests/hps_bridge_tb.sv

// File: Bender.yml
package:
  name: hps_bridge

sources:
  - source/hps_pkg.sv
  - source/hps_frame.sv
  - source/hps_input_regs.sv
  - source/hps_host_query.sv
  - source/hps_file_loader.sv
  - source/hps_response_arbiter.sv
  - source/hps_bridge.sv
  - target: test
    files:
      - tests/hps_bridge_assertions.sv
      - tests/hps_bridge_tb.sv

// File: tests/hps_bridge_tb.sv
/* directed testbench for the host command bridge; conf_str is sized by CONF_LEN
   and the host model holds each strobe back while io_wait is high */
`timescale 1ns/100ps

module hps_bridge_tb;

	// words per test: 4, 8, 5, 7, 1 + CONF_LEN and 26 for the download
	localparam int TOTAL_WORDS    = 51 + hps_pkg::CONF_LEN;
	localparam int TIMEOUT_CYCLES = 4 * TOTAL_WORDS + 200;

	logic                            clk_sys;
	logic                            reset;
	logic                            io_enable;
	logic                            io_strobe;
	hps_pkg::host_word_t             io_din;
	hps_pkg::host_word_t             io_dout;
	logic                            io_wait;
	logic [8*hps_pkg::CONF_LEN-1:0]  conf_str;
	logic [1:0]                      buttons;
	logic                            forced_scandoubler;
	hps_pkg::joy_t                   joystick_0;
	hps_pkg::joy_t                   joystick_1;
	hps_pkg::status_t                status;
	hps_pkg::status_t                status_in;
	logic                            status_set;
	hps_pkg::host_word_t             status_menumask;
	logic                            ioctl_download;
	logic [7:0]                      ioctl_index;
	logic                            ioctl_wr;
	hps_pkg::ioctl_addr_t            ioctl_addr;
	logic [7:0]                      ioctl_dout;
	hps_pkg::file_ext_t              ioctl_file_ext;
	logic                            ioctl_wait;

	// words sent by the host model and the replies it read back
	hps_pkg::host_word_t   tx_words [0:31];
	hps_pkg::host_word_t   rx_words [0:31];
	// writes seen on the core side
	logic [7:0]            wr_data [0:63];
	hps_pkg::ioctl_addr_t  wr_addr [0:63];
	int                    wr_count;
	int                    wr_outside;
	int                    value_errors;
	int                    other_errors;
	int                    cycle_count;
	logic                  stall_en;
	int unsigned           rnd_seed;

	hps_bridge dut0 (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// core model, write monitor and timeout
	//////////////////////////////////////////////////

	// the core stalls at random while stall_en is set
	always @(posedge clk_sys) begin
		#1;
		ioctl_wait = stall_en && ($urandom % 4 == 0);
	end

	// sampled on the falling edge, away from the flop updates
	always @(negedge clk_sys) begin
		if (ioctl_wr) begin
			if (!ioctl_download) begin
				wr_outside++;
			end
			if (wr_count < 64) begin
				wr_data[wr_count] = ioctl_dout;
				wr_addr[wr_count] = ioctl_addr;
			end
			wr_count++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Result: FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input hps_pkg::host_word_t got,
			input hps_pkg::host_word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_joy(input string name, input hps_pkg::joy_t got,
			input hps_pkg::joy_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input hps_pkg::status_t got,
			input hps_pkg::status_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input hps_pkg::ioctl_addr_t got,
			input hps_pkg::ioctl_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_ext(input string name, input hps_pkg::file_ext_t got,
			input hps_pkg::file_ext_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// host model
	//////////////////////////////////////////////////

	function automatic hps_pkg::host_word_t rand_word();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	// one frame; each reply is read a full cycle after its strobe
	task automatic send_frame(input int n);
		io_enable = 1'b1;
		for (int i = 0; i < n; i++) begin
			while (io_wait) begin
				@(posedge clk_sys);
				#2;
			end
			io_strobe = 1'b1;
			io_din    = tx_words[i];
			@(posedge clk_sys);
			#2;
			io_strobe = 1'b0;
			@(posedge clk_sys);
			#2;
			rx_words[i] = io_dout;
		end
		io_enable = 1'b0;
		@(posedge clk_sys);
		#2;
	endtask

	task automatic expect_silent(input int n);
		for (int i = 0; i < n; i++) begin
			check_word($sformatf("io_dout[%0d]", i), rx_words[i], '0);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_idle();
		check_word("io_dout", io_dout, '0);
		check_bit("ioctl_wr", ioctl_wr, 1'b0);
		check_bit("ioctl_download", ioctl_download, 1'b0);
		// no peer owns command 0x77
		tx_words[0] = 16'h0077;
		for (int i = 1; i < 4; i++) begin
			tx_words[i] = rand_word();
		end
		send_frame(4);
		expect_silent(4);
	endtask

	task automatic test_cfg_joy();
		hps_pkg::host_word_t cfg;
		hps_pkg::joy_t       j0;
		hps_pkg::joy_t       j1;
		cfg = rand_word();
		j0  = {rand_word(), rand_word()};
		j1  = {rand_word(), rand_word()};
		tx_words[0] = hps_pkg::CMD_CFG;
		tx_words[1] = cfg;
		send_frame(2);
		expect_silent(2);
		tx_words[0] = hps_pkg::CMD_JOY0;
		tx_words[1] = j0[15:0];
		tx_words[2] = j0[31:16];
		send_frame(3);
		expect_silent(3);
		tx_words[0] = hps_pkg::CMD_JOY1;
		tx_words[1] = j1[15:0];
		tx_words[2] = j1[31:16];
		send_frame(3);
		check_byte("buttons", {6'd0, buttons}, {6'd0, cfg[1:0]});
		check_bit("forced_scandoubler", forced_scandoubler, cfg[4]);
		check_joy("joystick_0", joystick_0, j0);
		check_joy("joystick_1", joystick_1, j1);
	endtask

	task automatic test_status();
		hps_pkg::host_word_t w [1:4];
		tx_words[0] = hps_pkg::CMD_STATUS;
		for (int k = 1; k <= 4; k++) begin
			w[k]        = rand_word();
			tx_words[k] = w[k];
		end
		send_frame(5);
		expect_silent(5);
		check_status("status", status, {w[4], w[3], w[2], w[1]});
	endtask

	task automatic test_status_req();
		hps_pkg::status_t last;
		for (int p = 0; p < 3; p++) begin
			last       = {rand_word(), rand_word(), rand_word(), rand_word()};
			status_in  = last;
			status_set = 1'b1;
			// held for two cycles so only the rising edge may count
			repeat (2) @(posedge clk_sys);
			#2;
			status_set = 1'b0;
			@(posedge clk_sys);
			#2;
		end
		tx_words[0] = hps_pkg::CMD_STATUS_REQ;
		for (int k = 1; k <= 4; k++) begin
			tx_words[k] = '0;
		end
		send_frame(5);
		check_word("io_dout[0]", rx_words[0], {8'h00, hps_pkg::STATUS_REQ_TAG, 4'd3});
		for (int k = 1; k <= 4; k++) begin
			check_word($sformatf("io_dout[%0d]", k), rx_words[k], last[(k-1)*16 +: 16]);
		end
		tx_words[0] = hps_pkg::CMD_MENUMASK;
		tx_words[1] = '0;
		send_frame(2);
		check_word("io_dout[0]", rx_words[0], '0);
		check_word("io_dout[1]", rx_words[1], status_menumask);
	endtask

	task automatic test_conf_str();
		hps_pkg::conf_byte_t chars [1:hps_pkg::CONF_LEN];
		hps_pkg::host_word_t r;
		conf_str    = '0;
		tx_words[0] = hps_pkg::CMD_CONF_STR;
		// first character ends up in the top byte
		for (int k = 1; k <= hps_pkg::CONF_LEN; k++) begin
			r           = rand_word();
			chars[k]    = r[7:0];
			conf_str    = (conf_str << 8) | chars[k];
			tx_words[k] = '0;
		end
		send_frame(hps_pkg::CONF_LEN + 1);
		check_word("io_dout[0]", rx_words[0], '0);
		for (int k = 1; k <= hps_pkg::CONF_LEN; k++) begin
			check_word($sformatf("io_dout[%0d]", k), rx_words[k], {8'h00, chars[k]});
		end
	endtask

	task automatic test_download();
		logic [7:0]          idx;
		logic [7:0]          bytes [0:15];
		hps_pkg::file_ext_t  ext;
		hps_pkg::host_word_t r;
		r   = rand_word();
		idx = r[7:0];
		ext = {rand_word(), rand_word()};
		tx_words[0] = hps_pkg::CMD_FILE_INDEX;
		tx_words[1] = {8'h00, idx};
		send_frame(2);
		tx_words[0] = hps_pkg::CMD_FILE_INFO;
		tx_words[1] = ext[31:16];
		tx_words[2] = ext[15:0];
		send_frame(3);
		tx_words[0] = hps_pkg::CMD_FILE_TX;
		tx_words[1] = 16'h00FF;
		send_frame(2);
		check_bit("ioctl_download", ioctl_download, 1'b1);
		wr_count   = 0;
		wr_outside = 0;
		// upper byte of each data word is junk and must be ignored
		tx_words[0] = hps_pkg::CMD_FILE_TX_DAT;
		for (int i = 0; i < 16; i++) begin
			r               = rand_word();
			bytes[i]        = r[7:0];
			tx_words[i + 1] = r;
		end
		stall_en = 1'b1;
		send_frame(17);
		stall_en = 1'b0;
		check_bit("ioctl_download", ioctl_download, 1'b1);
		if (wr_count != 16) begin
			other_errors++;
			$display("the core saw %0d write strobes instead of 16", wr_count);
		end else begin
			for (int i = 0; i < 16; i++) begin
				check_byte($sformatf("ioctl_dout[%0d]", i), wr_data[i], bytes[i]);
				check_addr($sformatf("ioctl_addr[%0d]", i), wr_addr[i], i);
			end
		end
		if (wr_outside != 0) begin
			other_errors++;
			$display("%0d write strobes came while the download was not active", wr_outside);
		end
		tx_words[0] = hps_pkg::CMD_FILE_TX;
		tx_words[1] = 16'h0000;
		send_frame(2);
		check_bit("ioctl_download", ioctl_download, 1'b0);
		check_addr("ioctl_addr", ioctl_addr, 27'd16);
		check_byte("ioctl_index", ioctl_index, idx);
		check_ext("ioctl_file_ext", ioctl_file_ext, ext);
	endtask

	initial begin
		rnd_seed        = 34;
		rnd_seed        = $urandom(rnd_seed);
		value_errors    = 0;
		other_errors    = 0;
		cycle_count     = 0;
		wr_count        = 0;
		wr_outside      = 0;
		stall_en        = 1'b0;
		reset           = 1'b1;
		io_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		conf_str        = '0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = rand_word();
		ioctl_wait      = 1'b0;
		repeat (8) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		@(posedge clk_sys);
		#2;
		test_idle();
		test_cfg_joy();
		test_status();
		test_status_req();
		test_conf_str();
		test_download();
		$display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
			value_errors, other_errors, dut0.u_assertions.assert_errors);
		if (value_errors == 0 && other_errors == 0 &&
				dut0.u_assertions.assert_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: tests/hps_bridge_assertions.sv
/* port-level checks bound into every hps_bridge instance
   all properties are disabled while reset is high */
`timescale 1ns/100ps

module hps_bridge_assertions (
	input logic                 clk_sys,
	input logic                 reset,
	input logic                 io_enable,
	input hps_pkg::host_word_t  io_dout,
	input logic                 io_wait,
	input logic                 ioctl_wait,
	input logic                 ioctl_wr,
	input logic                 ioctl_download
);

	// failures so far, read by the testbench at the end of the run
	int assert_errors;

	initial assert_errors = 0;

	// back-pressure is a straight wire
	a_wait_mirror: assert property (@(posedge clk_sys) disable iff (reset)
		io_wait == ioctl_wait)
		else begin
			assert_errors++;
			$error("io_wait does not follow ioctl_wait");
		end

	// one write strobe per data word
	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr)
		else begin
			assert_errors++;
			$error("ioctl_wr stayed high for more than one cycle");
		end

	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
		else begin
			assert_errors++;
			$error("ioctl_wr pulsed outside a download");
		end

	// reply bus clears between frames
	a_dout_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!io_enable |=> io_dout == '0)
		else begin
			assert_errors++;
			$error("io_dout not cleared after io_enable dropped");
		end

endmodule

bind hps_bridge hps_bridge_assertions u_assertions (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.io_enable      (io_enable),
	.io_dout        (io_dout),
	.io_wait        (io_wait),
	.ioctl_wait     (ioctl_wait),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

// File: source/hps_bridge.sv
/* host to core command bridge; one frame per io_enable level, one word per strobe
   io_wait follows ioctl_wait directly and nothing is queued behind it */
`timescale 1ns/100ps

module hps_bridge (
	input  logic                            clk_sys,
	input  logic                            reset,
	// host side
	input  logic                            io_enable,
	input  logic                            io_strobe,
	input  hps_pkg::host_word_t             io_din,
	output hps_pkg::host_word_t             io_dout,
	output logic                            io_wait,
	// core side
	input  logic [8*hps_pkg::CONF_LEN-1:0]  conf_str,
	output logic [1:0]                      buttons,
	output logic                            forced_scandoubler,
	output hps_pkg::joy_t                   joystick_0,
	output hps_pkg::joy_t                   joystick_1,
	output hps_pkg::status_t                status,
	input  hps_pkg::status_t                status_in,
	input  logic                            status_set,
	input  hps_pkg::host_word_t             status_menumask,
	output logic                            ioctl_download,
	output logic [7:0]                      ioctl_index,
	output logic                            ioctl_wr,
	output hps_pkg::ioctl_addr_t            ioctl_addr,
	output logic [7:0]                      ioctl_dout,
	output hps_pkg::file_ext_t              ioctl_file_ext,
	input  logic                            ioctl_wait
);

	logic                 word_strobe;
	hps_pkg::word_idx_t   word_idx;
	hps_pkg::host_word_t  cmd;
	logic                 query_claim;
	hps_pkg::host_word_t  query_word;

	assign io_wait = ioctl_wait;

	//////////////////////////////////////////////////
	// frame tracking
	//////////////////////////////////////////////////

	hps_frame u_frame (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.word_strobe (word_strobe),
		.word_idx    (word_idx),
		.cmd         (cmd)
	);

	//////////////////////////////////////////////////
	// command peers
	//////////////////////////////////////////////////

	hps_input_regs u_input_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.word_strobe        (word_strobe),
		.word_idx           (word_idx),
		.cmd                (cmd),
		.io_din             (io_din),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status)
	);

	hps_host_query u_host_query (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.word_idx        (word_idx),
		.cmd             (cmd),
		.conf_str        (conf_str),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.query_claim     (query_claim),
		.query_word      (query_word)
	);

	hps_file_loader u_file_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.word_strobe    (word_strobe),
		.word_idx       (word_idx),
		.cmd            (cmd),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext)
	);

	// reply path back to the host
	hps_response_arbiter u_response_arbiter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.word_strobe (word_strobe),
		.query_claim (query_claim),
		.query_word  (query_word),
		.io_dout     (io_dout)
	);

endmodule

// File: source/hps_response_arbiter.sv
/* registers the reply word onto io_dout; unclaimed words reply zero
   only the query peer answers reads, so it is the single request line */
`timescale 1ns/100ps

module hps_response_arbiter (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 io_enable,
	input  logic                 word_strobe,
	input  logic                 query_claim,
	input  hps_pkg::host_word_t  query_word,
	output hps_pkg::host_word_t  io_dout
);

	hps_pkg::host_word_t sel_word;

	// input regs and file loader never claim, so the query peer wins outright
	assign sel_word = query_claim ? query_word : '0;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			io_dout <= '0;
		end else if (!io_enable) begin
			io_dout <= '0;
		end else if (word_strobe) begin
			io_dout <= sel_word;
		end
	end

endmodule

// File: source/hps_file_loader.sv
/* byte-wide download to the core; the address steps by one per data word
   there is no buffer, so the host must hold off strobes while ioctl_wait is high */
`timescale 1ns/100ps

module hps_file_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  word_strobe,
	input  hps_pkg::word_idx_t    word_idx,
	input  hps_pkg::host_word_t   cmd,
	input  hps_pkg::host_word_t   io_din,
	output logic                  ioctl_download,
	output logic [7:0]            ioctl_index,
	output logic                  ioctl_wr,
	output hps_pkg::ioctl_addr_t  ioctl_addr,
	output logic [7:0]            ioctl_dout,
	output hps_pkg::file_ext_t    ioctl_file_ext
);

	hps_pkg::ioctl_addr_t addr_cnt;
	logic                 arg_strobe;

	// the command word itself never carries an argument
	assign arg_strobe = word_strobe && (word_idx != '0);

	//////////////////////////////////////////////////
	// download control and write strobe
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			addr_cnt       <= '0;
		end else begin
			ioctl_wr <= 1'b0;
			if (arg_strobe) begin
				case (cmd)
					hps_pkg::CMD_FILE_TX: begin
						if (io_din[7:0] != 8'h00) begin
							addr_cnt       <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// leave the byte count on the address lines
							ioctl_addr     <= addr_cnt;
							ioctl_download <= 1'b0;
						end
					end
					hps_pkg::CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr_cnt;
						ioctl_wr   <= 1'b1;
						addr_cnt   <= addr_cnt + 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// payload, index and extension
	always_ff @(posedge clk_sys) begin
		if (arg_strobe) begin
			case (cmd)
				hps_pkg::CMD_FILE_TX_DAT: ioctl_dout <= io_din[7:0];
				hps_pkg::CMD_FILE_INDEX: begin
					if (word_idx == 10'd1) ioctl_index <= io_din[7:0];
				end
				hps_pkg::CMD_FILE_INFO: begin
					if (word_idx == 10'd1) ioctl_file_ext[31:16] <= io_din;
					if (word_idx == 10'd2) ioctl_file_ext[15:0] <= io_din;
				end
				default: ;
			endcase
		end
	end

endmodule

// File: source/hps_host_query.sv
/* read-back of status requests, menu mask and config string
   status_set must be synchronous to clk_sys; the request count wraps at 16 */
`timescale 1ns/100ps

module hps_host_query (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  hps_pkg::word_idx_t                word_idx,
	input  hps_pkg::host_word_t               cmd,
	input  logic [8*hps_pkg::CONF_LEN-1:0]    conf_str,
	input  hps_pkg::status_t                  status_in,
	input  logic                              status_set,
	input  hps_pkg::host_word_t               status_menumask,
	output logic                              query_claim,
	output hps_pkg::host_word_t               query_word
);

	logic                 status_set_d;
	logic [3:0]           req_count;
	hps_pkg::status_t     status_req;
	hps_pkg::conf_byte_t  conf_char;

	//////////////////////////////////////////////////
	// status set requests from the core
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_d <= 1'b0;
			req_count    <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d) begin
				req_count <= req_count + 1'b1;
			end
		end
	end

	// value offered to the host with the request
	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d) begin
			status_req <= status_in;
		end
	end

	// character k of the string, first character in the top byte
	always_comb begin
		conf_char = '0;
		if (word_idx >= 10'd1 && word_idx <= hps_pkg::CONF_LEN) begin
			conf_char = conf_str[(hps_pkg::CONF_LEN - word_idx) * 8 +: 8];
		end
	end

	//////////////////////////////////////////////////
	// reply for the current word
	//////////////////////////////////////////////////

	always_comb begin
		query_claim = 1'b0;
		query_word  = '0;
		case (cmd)
			hps_pkg::CMD_STATUS_REQ: begin
				query_claim = (word_idx <= 10'd4);
				case (word_idx)
					10'd0: query_word = {8'h00, hps_pkg::STATUS_REQ_TAG, req_count};
					10'd1: query_word = status_req[15:0];
					10'd2: query_word = status_req[31:16];
					10'd3: query_word = status_req[47:32];
					10'd4: query_word = status_req[63:48];
					default: ;
				endcase
			end
			hps_pkg::CMD_MENUMASK: begin
				if (word_idx == 10'd1) begin
					query_claim = 1'b1;
					query_word  = status_menumask;
				end
			end
			hps_pkg::CMD_CONF_STR: begin
				if (word_idx >= 10'd1 && word_idx <= hps_pkg::CONF_LEN) begin
					query_claim = 1'b1;
					query_word  = {8'h00, conf_char};
				end
			end
			default: ;
		endcase
	end

endmodule

// File: source/hps_input_regs.sv
/* host-written config, joystick and status registers
   joysticks take two words and status four, each least significant first */
`timescale 1ns/100ps

module hps_input_regs (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 word_strobe,
	input  hps_pkg::word_idx_t   word_idx,
	input  hps_pkg::host_word_t  cmd,
	input  hps_pkg::host_word_t  io_din,
	output logic [1:0]           buttons,
	output logic                 forced_scandoubler,
	output hps_pkg::joy_t        joystick_0,
	output hps_pkg::joy_t        joystick_1,
	output hps_pkg::status_t     status
);

	logic [7:0] cfg;

	// bits 2, 3 and 5 belong to the system top and are kept only
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word_strobe) begin
			case (cmd)
				hps_pkg::CMD_CFG: begin
					if (word_idx == 10'd1) begin
						cfg <= io_din[7:0];
					end
				end
				hps_pkg::CMD_JOY0: begin
					case (word_idx)
						10'd1: joystick_0[15:0]  <= io_din;
						10'd2: joystick_0[31:16] <= io_din;
						default: ;
					endcase
				end
				hps_pkg::CMD_JOY1: begin
					case (word_idx)
						10'd1: joystick_1[15:0]  <= io_din;
						10'd2: joystick_1[31:16] <= io_din;
						default: ;
					endcase
				end
				// 64-bit status in four words
				hps_pkg::CMD_STATUS: begin
					case (word_idx)
						10'd1: status[15:0]  <= io_din;
						10'd2: status[31:16] <= io_din;
						10'd3: status[47:32] <= io_din;
						10'd4: status[63:48] <= io_din;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

endmodule

// File: source/hps_frame.sv
/* frame tracker; io_enable must stay high for the whole frame
   and io_din is only sampled together with io_strobe */
`timescale 1ns/100ps

module hps_frame (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 io_enable,
	input  logic                 io_strobe,
	input  hps_pkg::host_word_t  io_din,
	output logic                 word_strobe,
	output hps_pkg::word_idx_t   word_idx,
	output hps_pkg::host_word_t  cmd
);

	hps_pkg::host_word_t cmd_reg;

	// strobes outside a frame are ignored
	assign word_strobe = io_strobe & io_enable;

	// first word is the command itself
	assign cmd = (word_idx == '0) ? io_din : cmd_reg;

	//////////////////////////////////////////////////
	// word counter and command capture
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			word_idx <= '0;
			cmd_reg  <= '0;
		end else if (!io_enable) begin
			word_idx <= '0;
			cmd_reg  <= '0;
		end else if (word_strobe) begin
			if (word_idx == '0) begin
				cmd_reg <= io_din;
			end
			// counter holds at its top value on very long frames
			if (word_idx != '1) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

endmodule

// File: source/hps_pkg.sv
/* shared widths, command codes and string length for the host command bridge
   conf_str on the top level must be exactly CONF_LEN characters */
package hps_pkg;

	//////////////////////////////////////////////////
	// word and field types
	//////////////////////////////////////////////////

	// one word on the host bus
	typedef logic [15:0] host_word_t;
	// position in a frame, 0 is the command word
	typedef logic [9:0]  word_idx_t;
	typedef logic [63:0] status_t;
	typedef logic [31:0] joy_t;
	// download address counts bytes
	typedef logic [26:0] ioctl_addr_t;
	typedef logic [31:0] file_ext_t;
	typedef logic [7:0]  conf_byte_t;

	//////////////////////////////////////////////////
	// command words
	//////////////////////////////////////////////////

	localparam host_word_t CMD_CFG         = 16'h0001;
	localparam host_word_t CMD_JOY0        = 16'h0002;
	localparam host_word_t CMD_JOY1        = 16'h0003;
	localparam host_word_t CMD_CONF_STR    = 16'h0014;
	localparam host_word_t CMD_STATUS      = 16'h001E;
	localparam host_word_t CMD_STATUS_REQ  = 16'h0029;
	localparam host_word_t CMD_MENUMASK    = 16'h002E;
	localparam host_word_t CMD_FILE_TX     = 16'h0053;
	localparam host_word_t CMD_FILE_TX_DAT = 16'h0054;
	localparam host_word_t CMD_FILE_INDEX  = 16'h0055;
	localparam host_word_t CMD_FILE_INFO   = 16'h0056;

	// upper nibble of the status request reply
	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

	// characters in conf_str
	localparam int CONF_LEN = 4;

endpackage
